/* tyr_core.f */
source/tyr_pkg.sv
source/tyr_fetch.sv
source/tyr_regfile.sv
source/tyr_decode.sv
source/tyr_execute.sv
source/tyr_core.sv
verification/tyr_clock_gen.sv
verification/tyr_core_tb.sv

/* Bender.yml */
package:
  name: tyr_core

sources:
  - files:
      - source/tyr_pkg.sv
      - source/tyr_fetch.sv
      - source/tyr_regfile.sv
      - source/tyr_decode.sv
      - source/tyr_execute.sv
      - source/tyr_core.sv
  - target: test
    files:
      - verification/tyr_clock_gen.sv
      - verification/tyr_core_tb.sv

/* verification/tyr_core_tb.sv */
`timescale 1ns/1ps

module tyr_core_tb;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
    localparam int          IMEM_WORDS   = 128;
    localparam logic [3:0]  OP_OR        = 4'd0;
    localparam logic [3:0]  OP_ADD       = 4'd2;
    localparam logic [3:0]  OP_XOR       = 4'd10;
    localparam logic [3:0]  OP_SUB       = 4'd11;

    logic        clk;
    logic        reset_n;
    logic        i_en;
    logic [31:0] i_insn_data;
    logic [31:0] i_mem_rdata;
    logic [31:0] o_insn_addr;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic        o_mem_we;
    logic        o_mem_re;
    logic        o_halt;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:255];          // Low address byte picks the word
    logic [31:0] exp_addr [0:63];
    logic [31:0] exp_data [0:63];
    logic [31:0] exp_halt = 32'd0;
    logic [31:0] exp_a;
    logic [31:0] exp_d;
    logic [7:0]  st_idx = 8'd0;
    logic        rst_prev = 1'b0;
    logic [31:0] lfsr_q = 32'h27a82846;
    int          exp_cnt = 0;
    int          prog_len = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          reset_errs = 0;
    int          store_errs = 0;
    int          halt_errs = 0;

    tyr_clock_gen clock_gen_inst (.o_clk(clk), .o_reset_n(reset_n));

    tyr_core #(.RESET_VECTOR(RESET_VECTOR)) tyr_core_inst (
        .clk(clk), .reset_n(reset_n), .i_en(i_en),
        .i_insn_data(i_insn_data), .i_mem_rdata(i_mem_rdata),
        .o_insn_addr(o_insn_addr), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .o_mem_we(o_mem_we), .o_mem_re(o_mem_re), .o_halt(o_halt)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'd0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [3:0] pick_reg();
        return 4'd1 + 4'(take_bits(3));  // r1 to r8
    endfunction

    function automatic logic [31:0] encode(input logic typ, input logic [1:0] deref,
                                           input logic [3:0] z, input logic [3:0] x,
                                           input logic [3:0] y, input logic [3:0] op,
                                           input logic [11:0] imm);
        return {1'b0, typ, deref, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            4'd0:    return a | b;
            4'd1:    return a & b;
            4'd2:    return a + b;
            4'd3:    return a * b;
            4'd5:    return (b > 32'd31) ? 32'd0 : a << b[4:0];
            4'd6:    return (a < b) ? 32'hffff_ffff : 32'd0;
            4'd7:    return (a == b) ? 32'hffff_ffff : 32'd0;
            4'd8:    return (a > b) ? 32'hffff_ffff : 32'd0;
            4'd9:    return a & ~b;
            4'd10:   return a ^ b;
            4'd11:   return a - b;
            4'd12:   return a ^ ~b;
            4'd13:   return (b > 32'd31) ? 32'd0 : a >> b[4:0];
            4'd14:   return (a != b) ? 32'hffff_ffff : 32'd0;
            default: return 32'd0;  // Reserved
        endcase
    endfunction

    function automatic logic [31:0] insn_at(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_VECTOR;
        if (off < IMEM_WORDS)
            return imem[off[6:0]];
        return 32'hf000_0000;  // Outside the program
    endfunction

    assign i_insn_data = insn_at(o_insn_addr);
    assign i_mem_rdata = dmem[o_mem_addr[7:0]];

    task automatic put(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        logic [3:0]  rz;
        logic [3:0]  rx;
        logic [3:0]  ry;
        logic [31:0] imm;
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = 32'hf000_0000 | i;
        for (int i = 0; i < 8; i++)
            dmem[i] = take_bits(32);
        for (int i = 1; i <= 8; i++)  // Random operands into r1..r8
            put(encode(1'b0, 2'b01, 4'(i), 4'd0, 4'd0, OP_OR, 12'(i - 1)));
        for (int op = 0; op < 16; op++) begin
            for (int t = 0; t < 2; t++) begin
                rz  = pick_reg();
                rx  = pick_reg();
                ry  = pick_reg();
                imm = (t == 1 && (op == 5 || op == 13)) ? take_bits(5) : take_bits(12);
                put(encode(1'(t), 2'b10, rz, rx, ry, 4'(op), imm[11:0]));
            end
        end
        put(encode(1'b0, 2'b00, 4'd9, 4'd1, 4'd0, OP_ADD, 12'h013));
        put(encode(1'b0, 2'b00, 4'd10, 4'd9, 4'd2, OP_XOR, 12'h000));  // Needs r9 forwarded
        put(encode(1'b0, 2'b11, 4'd10, 4'd9, 4'd0, OP_OR, 12'h000));
        put(encode(1'b0, 2'b00, 4'd0, 4'd1, 4'd2, OP_ADD, 12'h7ff));   // Dropped write
        put(encode(1'b1, 2'b10, 4'd9, 4'd0, 4'd0, OP_OR, 12'h055));
        put(encode(1'b0, 2'b01, 4'd11, 4'd9, 4'd0, OP_OR, 12'h000));   // Load back
        put(encode(1'b0, 2'b11, 4'd11, 4'd0, 4'd0, OP_OR, 12'h020));
        put(encode(1'b0, 2'b10, 4'd12, 4'd11, 4'd3, OP_SUB, 12'h001));
        put(encode(1'b0, 2'b00, 4'd15, 4'd15, 4'd0, OP_ADD, 12'd3));   // Jump ahead by four
        for (int k = 0; k < 3; k++)
            put(encode(1'b0, 2'b11, 4'd1, 4'd0, 4'd0, OP_OR, 12'(12'h0e0 + k)));
        put(encode(1'b0, 2'b11, 4'd15, 4'd0, 4'd0, OP_OR, 12'h030));  // Stores own address + 1
        put(32'h8abc_def0);
        put(encode(1'b0, 2'b11, 4'd2, 4'd0, 4'd0, OP_OR, 12'h031));
        put(32'hf000_0000);
        for (int k = 0; k < 3; k++)
            put(encode(1'b0, 2'b11, 4'd3, 4'd0, 4'd0, OP_OR, 12'(12'h0f0 + k)));
    endtask

    // In-order interpreter of the same program
    task automatic run_model();
        logic [31:0] regs [0:15];
        logic [31:0] mem [0:255];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] xv;
        logic [31:0] yv;
        logic [31:0] zv;
        logic [31:0] imm_x;
        logic [31:0] rhs;
        logic [3:0]  zi;
        bit          done;
        int          steps;
        for (int i = 0; i < 16; i++)
            regs[i] = 32'd0;
        for (int i = 0; i < 256; i++)
            mem[i] = dmem[i];
        pc    = RESET_VECTOR;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w = insn_at(pc);
            steps++;
            if (w[31:28] == 4'hf) begin
                exp_halt = pc + 32'd3;  // Fetch has moved on twice by then
                done     = 1'b1;
            end else if (w[31]) begin
                pc = pc + 32'd1;
            end else begin
                zi    = w[27:24];
                xv    = (w[23:20] == 4'd15) ? pc + 32'd1 : regs[w[23:20]];
                yv    = (w[19:16] == 4'd15) ? pc + 32'd1 : regs[w[19:16]];
                zv    = (zi == 4'd15) ? pc + 32'd1 : regs[zi];
                imm_x = {{20{w[11]}}, w[11:0]};
                if (w[30])
                    rhs = alu_ref(w[15:12], xv, imm_x) + yv;
                else
                    rhs = alu_ref(w[15:12], xv, yv) + imm_x;
                if (w[29]) begin
                    exp_addr[exp_cnt] = w[28] ? rhs : zv;
                    exp_data[exp_cnt] = w[28] ? zv : rhs;
                    mem[exp_addr[exp_cnt][7:0]] = exp_data[exp_cnt];
                    exp_cnt++;
                    pc = pc + 32'd1;
                end else begin
                    if (w[28])
                        rhs = mem[rhs[7:0]];
                    if (zi == 4'd15) begin
                        pc = rhs;
                    end else begin
                        if (zi != 4'd0)
                            regs[zi] = rhs;
                        pc = pc + 32'd1;
                    end
                end
            end
        end
        if (!done) begin
            halt_errs++;
            $display("reference model never reached the illegal word");
        end
    endtask

    task automatic report_counts();
        $display("errors: reset %0d, store %0d, halt %0d", reset_errs, store_errs, halt_errs);
    endtask

    assign exp_a = exp_addr[st_idx[5:0]];
    assign exp_d = exp_data[st_idx[5:0]];

    always @(posedge clk) begin
        rst_prev <= reset_n;
        if (!reset_n && o_mem_we) begin
            dmem[o_mem_addr[7:0]] <= o_mem_wdata;
            st_idx <= st_idx + 8'd1;
        end
    end

    // Mostly enabled, with random freeze cycles
    always @(posedge clk)
        i_en <= #2 (take_bits(3) != 3'd0);

    a_reset_pc: assert property (@(posedge clk) rst_prev |-> o_insn_addr == RESET_VECTOR)
        else begin
            reset_errs++;
            $display("[FAIL] o_insn_addr in reset: got %h, expected %h",
                     $sampled(o_insn_addr), RESET_VECTOR);
        end

    a_reset_quiet: assert property (
        @(posedge clk) rst_prev |-> !o_mem_we && !o_mem_re && !o_halt
    ) else begin
        reset_errs++;
        $display("a strobe or halt was active during reset");
    end

    a_store_expected: assert property (
        @(posedge clk) disable iff (reset_n) o_mem_we |-> st_idx < exp_cnt
    ) else begin
        store_errs++;
        $display("store issued after all expected stores were seen");
    end

    a_store_addr: assert property (
        @(posedge clk) disable iff (reset_n) o_mem_we && st_idx < exp_cnt |-> o_mem_addr == exp_a
    ) else begin
        store_errs++;
        $display("[FAIL] o_mem_addr, store %0d: got %h, expected %h",
                 $sampled(st_idx), $sampled(o_mem_addr), $sampled(exp_a));
    end

    a_store_data: assert property (
        @(posedge clk) disable iff (reset_n) o_mem_we && st_idx < exp_cnt |-> o_mem_wdata == exp_d
    ) else begin
        store_errs++;
        $display("[FAIL] o_mem_wdata, store %0d: got %h, expected %h",
                 $sampled(st_idx), $sampled(o_mem_wdata), $sampled(exp_d));
    end

    a_halt_addr: assert property (
        @(posedge clk) disable iff (reset_n) o_halt |-> o_insn_addr == exp_halt
    ) else begin
        halt_errs++;
        $display("[FAIL] o_insn_addr at halt: got %h, expected %h",
                 $sampled(o_insn_addr), exp_halt);
    end

    a_halt_hold: assert property (
        @(posedge clk) disable iff (reset_n)
        o_halt |=> o_halt && $stable(o_insn_addr) && !o_mem_we
    ) else begin
        halt_errs++;
        $display("core left the halted state, moved its PC or stored while halted");
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: core did not halt within %0d cycles", cycle_limit);
            report_counts();
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        i_en = 1'b1;
        build_program();
        run_model();
        cycle_limit = 3 * prog_len + 64;  // Room for reset and random freezes
        @(negedge reset_n);
        wait (o_halt === 1'b1);
        repeat (4) @(posedge clk);
        if (st_idx != exp_cnt) begin
            store_errs++;
            $display("saw %0d stores where %0d were expected", st_idx, exp_cnt);
        end
        report_counts();
        if (reset_errs + store_errs + halt_errs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* verification/tyr_clock_gen.sv */
`timescale 1ns/1ps

module tyr_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_reset_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Active high, released just after an edge
    initial begin
        o_reset_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset_n = 1'b0;
    end

endmodule

/* source/tyr_core.sv */
`timescale 1ns/1ps

module tyr_core import tyr_pkg::*; #(
    parameter logic [31:0] RESET_VECTOR = 32'h0
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_en,
    input  logic [31:0] i_insn_data,
    input  logic [31:0] i_mem_rdata,
    output logic [31:0] o_insn_addr,
    output logic [31:0] o_mem_addr,
    output logic [31:0] o_mem_wdata,
    output logic        o_mem_we,
    output logic        o_mem_re,
    output logic        o_halt
);

    insn_u       f_insn;
    logic [31:0] f_pc;
    logic        f_valid;

    logic [3:0]  rd_x_idx;
    logic [3:0]  rd_y_idx;
    logic [3:0]  rd_z_idx;
    logic [31:0] rd_x;
    logic [31:0] rd_y;
    logic [31:0] rd_z;

    logic [31:0] d_x;
    logic [31:0] d_y;
    logic [31:0] d_z;
    logic [11:0] d_imm;
    alu_op_e     d_op;
    logic        d_type;
    logic [1:0]  d_deref;
    logic [3:0]  d_zidx;
    logic        d_valid;
    logic        d_illegal;

    logic        wr_en;
    logic [3:0]  wr_idx;
    logic [31:0] wr_data;
    logic        redirect;
    logic [31:0] redirect_addr;

    tyr_fetch #(.RESET_VECTOR(RESET_VECTOR)) fetch_inst (
        .clk(clk), .reset_n(reset_n), .i_en(i_en),
        .i_insn_data(i_insn_data),
        .i_redirect(redirect), .i_redirect_addr(redirect_addr),
        .i_halt(o_halt),
        .o_insn_addr(o_insn_addr),
        .o_f_insn(f_insn), .o_f_pc(f_pc), .o_f_valid(f_valid)
    );

    tyr_regfile regfile_inst (
        .clk(clk), .reset_n(reset_n),
        .i_rd_x_idx(rd_x_idx), .i_rd_y_idx(rd_y_idx), .i_rd_z_idx(rd_z_idx),
        .i_wr_en(wr_en), .i_wr_idx(wr_idx), .i_wr_data(wr_data),
        .o_rd_x(rd_x), .o_rd_y(rd_y), .o_rd_z(rd_z)
    );

    // Forwarding taps the execute write port directly
    tyr_decode decode_inst (
        .clk(clk), .reset_n(reset_n), .i_en(i_en),
        .i_f_insn(f_insn), .i_f_pc(f_pc), .i_f_valid(f_valid), .i_flush(redirect),
        .i_rd_x(rd_x), .i_rd_y(rd_y), .i_rd_z(rd_z),
        .i_fwd_en(wr_en), .i_fwd_idx(wr_idx), .i_fwd_data(wr_data),
        .o_rd_x_idx(rd_x_idx), .o_rd_y_idx(rd_y_idx), .o_rd_z_idx(rd_z_idx),
        .o_d_x(d_x), .o_d_y(d_y), .o_d_z(d_z), .o_d_imm(d_imm), .o_d_op(d_op),
        .o_d_type(d_type), .o_d_deref(d_deref), .o_d_zidx(d_zidx),
        .o_d_valid(d_valid), .o_d_illegal(d_illegal)
    );

    tyr_execute execute_inst (
        .clk(clk), .reset_n(reset_n), .i_en(i_en),
        .i_d_x(d_x), .i_d_y(d_y), .i_d_z(d_z), .i_d_imm(d_imm), .i_d_op(d_op),
        .i_d_type(d_type), .i_d_deref(d_deref), .i_d_zidx(d_zidx),
        .i_d_valid(d_valid), .i_d_illegal(d_illegal),
        .i_mem_rdata(i_mem_rdata),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .o_mem_we(o_mem_we), .o_mem_re(o_mem_re),
        .o_wr_en(wr_en), .o_wr_idx(wr_idx), .o_wr_data(wr_data),
        .o_redirect(redirect), .o_redirect_addr(redirect_addr),
        .o_halt(o_halt)
    );

endmodule

/* source/tyr_execute.sv */
`timescale 1ns/1ps

module tyr_execute import tyr_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_en,
    input  logic [31:0] i_d_x,
    input  logic [31:0] i_d_y,
    input  logic [31:0] i_d_z,
    input  logic [11:0] i_d_imm,
    input  alu_op_e     i_d_op,
    input  logic        i_d_type,
    input  logic [1:0]  i_d_deref,
    input  logic [3:0]  i_d_zidx,
    input  logic        i_d_valid,
    input  logic        i_d_illegal,
    input  logic [31:0] i_mem_rdata,
    output logic [31:0] o_mem_addr,
    output logic [31:0] o_mem_wdata,
    output logic        o_mem_we,
    output logic        o_mem_re,
    output logic        o_wr_en,
    output logic [3:0]  o_wr_idx,
    output logic [31:0] o_wr_data,
    output logic        o_redirect,
    output logic [31:0] o_redirect_addr,
    output logic        o_halt
);

    logic [31:0] imm_x;
    logic [31:0] opnd;
    logic [31:0] addend;
    logic [31:0] alu;
    logic [31:0] rhs;
    logic        active;
    logic        to_reg;
    logic        halt_q;

    assign imm_x  = sext_imm(i_d_imm);
    assign opnd   = i_d_type ? imm_x : i_d_y;  // Type 1 swaps Y and immediate
    assign addend = i_d_type ? i_d_y : imm_x;

    always_comb begin
        case (i_d_op)
            OP_OR:   alu = i_d_x | opnd;
            OP_AND:  alu = i_d_x & opnd;
            OP_ADD:  alu = i_d_x + opnd;
            OP_MUL:  alu = i_d_x * opnd;
            OP_SHL:  alu = i_d_x << opnd;
            OP_CLT:  alu = {32{i_d_x < opnd}};   // True is all ones
            OP_CEQ:  alu = {32{i_d_x == opnd}};
            OP_CGT:  alu = {32{i_d_x > opnd}};
            OP_ANDN: alu = i_d_x & ~opnd;
            OP_XOR:  alu = i_d_x ^ opnd;
            OP_SUB:  alu = i_d_x - opnd;
            OP_XORN: alu = i_d_x ^ ~opnd;
            OP_SHR:  alu = i_d_x >> opnd;
            OP_CNE:  alu = {32{i_d_x != opnd}};
            default: alu = 32'd0;                // Reserved codes
        endcase
    end

    assign rhs = alu + addend;

    assign active = i_en && i_d_valid && !i_d_illegal && !halt_q;
    assign to_reg = active && !i_d_deref[1];

    // Load or store address is the result, except 10 which addresses Z
    assign o_mem_addr  = i_d_deref[0] ? rhs : i_d_z;
    assign o_mem_wdata = i_d_deref[0] ? i_d_z : rhs;
    assign o_mem_we    = active && i_d_deref[1];
    assign o_mem_re    = active && (i_d_deref == 2'b01);

    assign o_wr_idx  = i_d_zidx;
    assign o_wr_data = i_d_deref[0] ? i_mem_rdata : rhs;
    assign o_wr_en   = to_reg && i_d_zidx != REG_ZERO && i_d_zidx != REG_P;

    // Writing P is a jump
    assign o_redirect      = to_reg && i_d_zidx == REG_P;
    assign o_redirect_addr = o_wr_data;

    assign o_halt = halt_q;

    always_ff @(posedge clk) begin
        if (reset_n)
            halt_q <= 1'b0;
        else if (i_en && i_d_valid && i_d_illegal)
            halt_q <= 1'b1;
    end

    a_we_re_exclusive: assert property (
        @(posedge clk) disable iff (reset_n) !(o_mem_we && o_mem_re)
    ) else $error("store and load strobes together");

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (reset_n) o_halt |=> o_halt
    ) else $error("halt dropped without reset");

endmodule

/* source/tyr_decode.sv */
`timescale 1ns/1ps

module tyr_decode import tyr_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_en,
    input  insn_u       i_f_insn,
    input  logic [31:0] i_f_pc,
    input  logic        i_f_valid,
    input  logic        i_flush,
    input  logic [31:0] i_rd_x,
    input  logic [31:0] i_rd_y,
    input  logic [31:0] i_rd_z,
    input  logic        i_fwd_en,
    input  logic [3:0]  i_fwd_idx,
    input  logic [31:0] i_fwd_data,
    output logic [3:0]  o_rd_x_idx,
    output logic [3:0]  o_rd_y_idx,
    output logic [3:0]  o_rd_z_idx,
    output logic [31:0] o_d_x,
    output logic [31:0] o_d_y,
    output logic [31:0] o_d_z,
    output logic [11:0] o_d_imm,
    output alu_op_e     o_d_op,
    output logic        o_d_type,
    output logic [1:0]  o_d_deref,
    output logic [3:0]  o_d_zidx,
    output logic        o_d_valid,
    output logic        o_d_illegal
);

    logic [31:0] pc_plus1;
    logic        legal;
    logic        illegal;
    logic        keep;
    logic [31:0] x_val;
    logic [31:0] y_val;
    logic [31:0] z_val;

    // P+1, then the result being written this cycle, then the file
    function automatic logic [31:0] operand(input logic [3:0] idx, input logic [31:0] rf_val,
                                            input logic [31:0] pc1, input logic fwd_en,
                                            input logic [3:0] fwd_idx,
                                            input logic [31:0] fwd_data);
        if (idx == REG_P)
            return pc1;
        if (fwd_en && fwd_idx == idx && idx != REG_ZERO)
            return fwd_data;
        return rf_val;
    endfunction

    assign o_rd_x_idx = i_f_insn.fields.x;
    assign o_rd_y_idx = i_f_insn.fields.y;
    assign o_rd_z_idx = i_f_insn.fields.z;

    assign pc_plus1 = i_f_pc + 32'd1;
    assign legal    = insn_is_legal(i_f_insn);
    assign illegal  = insn_is_illegal(i_f_insn);
    assign keep     = i_f_valid && !i_flush;  // Younger than a jump otherwise

    assign x_val = operand(o_rd_x_idx, i_rd_x, pc_plus1, i_fwd_en, i_fwd_idx, i_fwd_data);
    assign y_val = operand(o_rd_y_idx, i_rd_y, pc_plus1, i_fwd_en, i_fwd_idx, i_fwd_data);
    assign z_val = operand(o_rd_z_idx, i_rd_z, pc_plus1, i_fwd_en, i_fwd_idx, i_fwd_data);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            o_d_valid   <= 1'b0;
            o_d_illegal <= 1'b0;
        end else if (i_en) begin
            o_d_valid   <= keep && (legal || illegal); // Invalid words become bubbles
            o_d_illegal <= keep && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_d_x     <= x_val;
            o_d_y     <= y_val;
            o_d_z     <= z_val;
            o_d_imm   <= i_f_insn.fields.imm;
            o_d_op    <= i_f_insn.fields.op;
            o_d_type  <= i_f_insn.fields.typ;
            o_d_deref <= i_f_insn.fields.deref;
            o_d_zidx  <= i_f_insn.fields.z;
        end
    end

endmodule

/* source/tyr_regfile.sv */
`timescale 1ns/1ps

module tyr_regfile import tyr_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [3:0]  i_rd_x_idx,
    input  logic [3:0]  i_rd_y_idx,
    input  logic [3:0]  i_rd_z_idx,
    input  logic        i_wr_en,
    input  logic [3:0]  i_wr_idx,
    input  logic [31:0] i_wr_data,
    output logic [31:0] o_rd_x,
    output logic [31:0] o_rd_y,
    output logic [31:0] o_rd_z
);

    // Only the general registers live here; P is kept by fetch
    logic [31:0] regs_q [1:14];

    // Index 0 and P read as zero, P is replaced in decode
    assign o_rd_x = (i_rd_x_idx == REG_ZERO || i_rd_x_idx == REG_P) ? 32'd0
                                                                    : regs_q[i_rd_x_idx];
    assign o_rd_y = (i_rd_y_idx == REG_ZERO || i_rd_y_idx == REG_P) ? 32'd0
                                                                    : regs_q[i_rd_y_idx];
    assign o_rd_z = (i_rd_z_idx == REG_ZERO || i_rd_z_idx == REG_P) ? 32'd0
                                                                    : regs_q[i_rd_z_idx];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 1; i <= 14; i++)
                regs_q[i] <= 32'd0;
        end else if (i_wr_en && i_wr_idx != REG_ZERO && i_wr_idx != REG_P) begin
            regs_q[i_wr_idx] <= i_wr_data;
        end
    end

    // Execute turns Z=0 into a drop and Z=P into a redirect
    a_no_special_write: assert property (
        @(posedge clk) disable iff (reset_n)
        i_wr_en |-> (i_wr_idx != REG_ZERO && i_wr_idx != REG_P)
    ) else $error("register write to index %0d", i_wr_idx);

endmodule

/* source/tyr_fetch.sv */
`timescale 1ns/1ps

module tyr_fetch import tyr_pkg::*; #(
    parameter logic [31:0] RESET_VECTOR = 32'h0
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_en,
    input  logic [31:0] i_insn_data,
    input  logic        i_redirect,
    input  logic [31:0] i_redirect_addr,
    input  logic        i_halt,
    output logic [31:0] o_insn_addr,
    output insn_u       o_f_insn,
    output logic [31:0] o_f_pc,
    output logic        o_f_valid
);

    logic [31:0] pc_q;

    assign o_insn_addr = pc_q;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc_q      <= RESET_VECTOR;
            o_f_valid <= 1'b0;
        end else if (i_en) begin
            if (i_redirect)
                pc_q <= i_redirect_addr; // Jump from execute
            else if (!i_halt)
                pc_q <= pc_q + 32'd1;
            o_f_valid <= !i_redirect;    // Drop the word fetched on the old path
        end
    end

    // Fetched word and its address
    always_ff @(posedge clk) begin
        if (i_en) begin
            o_f_insn <= i_insn_data;
            o_f_pc   <= pc_q;
        end
    end

    // Wrong-path word must not reach decode
    a_redirect_flush: assert property (
        @(posedge clk) disable iff (reset_n) (i_en && i_redirect) |=> !o_f_valid
    ) else $error("fetch kept a word across a redirect");

endmodule

/* source/tyr_pkg.sv */
package tyr_pkg;

    localparam logic [3:0] REG_ZERO      = 4'd0;  // Reads as zero, writes dropped
    localparam logic [3:0] REG_P         = 4'd15; // Program counter
    localparam logic [3:0] CLASS_ILLEGAL = 4'hf;

    typedef enum logic [3:0] {
        OP_OR   = 4'd0,
        OP_AND  = 4'd1,
        OP_ADD  = 4'd2,
        OP_MUL  = 4'd3,
        OP_SHL  = 4'd5,
        OP_CLT  = 4'd6,
        OP_CEQ  = 4'd7,
        OP_CGT  = 4'd8,
        OP_ANDN = 4'd9,
        OP_XOR  = 4'd10,
        OP_SUB  = 4'd11,
        OP_XORN = 4'd12,
        OP_SHR  = 4'd13,
        OP_CNE  = 4'd14
    } alu_op_e;

    // Normal instruction layout
    typedef struct packed {
        logic        cls;   // Set for invalid and illegal words
        logic        typ;   // Swaps Y and immediate
        logic [1:0]  deref;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        alu_op_e     op;
        logic [11:0] imm;
    } insn_fields_t;

    // Coarse view for classification
    typedef struct packed {
        logic [3:0]  nib;
        logic [27:0] payload;
    } insn_class_t;

    typedef union packed {
        insn_fields_t fields;
        insn_class_t  cls;
    } insn_u;

    function automatic logic insn_is_legal(input insn_u w);
        return !w.cls.nib[3];
    endfunction

    function automatic logic insn_is_illegal(input insn_u w);
        return w.cls.nib == CLASS_ILLEGAL;
    endfunction

    function automatic logic [31:0] sext_imm(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

endpackage
